// File: flist.f
hdl/cache_status_pkg.sv
hdl/line_write_if.sv
hdl/status_memory.sv
hdl/tag_memory.sv
hdl/lookup_compare.sv
hdl/cache_lookup.sv
tb/tb_cache_lookup.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cache_lookup \
    -f flist.f -o sim_tb || { echo "Verilator build failed"; exit 1; }

output="$(./obj_dir/sim_tb)"
echo "$output"
echo "$output" | grep -qx "Testbench passed" && exit 0 || exit 1

// File: tb/tb_cache_lookup.sv
module tb_cache_lookup;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_status_pkg::*;

    localparam int INDEX_WIDTH   = DEFAULT_INDEX_WIDTH;
    localparam int TAG_WIDTH     = tag_width(INDEX_WIDTH);
    localparam int DEPTH         = 1 << INDEX_WIDTH;
    localparam int RANDOM_CYCLES = 400;
    localparam int RESP_TIMEOUT  = 8;

    logic                 clk_i = 1'b0;
    logic                 rst_n_i;
    addr_t                wr_addr;
    logic                 wr_valid_we;
    logic                 wr_dirty_we;
    logic                 wr_valid;
    logic                 wr_dirty;
    addr_t                p0_addr;
    addr_t                p1_addr;
    logic                 p0_lookup;
    logic                 p1_lookup;
    logic                 p0_resp_valid;
    logic                 p0_hit;
    logic                 p0_dirty;
    logic [TAG_WIDTH-1:0] p0_victim_tag;
    logic                 p1_resp_valid;
    logic                 p1_hit;
    logic                 p1_dirty_hit;

    // line state model and expected responses
    logic                 model_valid [DEPTH];
    logic                 model_dirty [DEPTH];
    logic [TAG_WIDTH-1:0] model_tag   [DEPTH];
    logic                 exp_p0_resp;
    logic                 exp_p0_hit;
    logic                 exp_p0_dirty;
    logic                 exp_p0_line_valid;
    logic [TAG_WIDTH-1:0] exp_p0_victim;
    logic                 exp_p1_resp;
    logic                 exp_p1_hit;
    logic                 exp_p1_dirty_hit;

    logic [INDEX_WIDTH-1:0] wr_idx;
    logic [INDEX_WIDTH-1:0] p0_idx;
    logic [INDEX_WIDTH-1:0] p1_idx;
    logic [TAG_WIDTH-1:0]   wr_tag;
    logic [TAG_WIDTH-1:0]   p0_tag;
    logic [TAG_WIDTH-1:0]   p1_tag;

    int          seed = 52;
    logic [31:0] r;
    addr_t       addr_a;
    addr_t       addr_b;
    addr_t       addr_c;

    cache_lookup #(.INDEX_WIDTH(INDEX_WIDTH)) dut_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .wr_addr_i       (wr_addr),
        .wr_valid_we_i   (wr_valid_we),
        .wr_dirty_we_i   (wr_dirty_we),
        .wr_valid_i      (wr_valid),
        .wr_dirty_i      (wr_dirty),
        .p0_addr_i       (p0_addr),
        .p1_addr_i       (p1_addr),
        .p0_lookup_i     (p0_lookup),
        .p1_lookup_i     (p1_lookup),
        .p0_resp_valid_o (p0_resp_valid),
        .p0_hit_o        (p0_hit),
        .p0_dirty_o      (p0_dirty),
        .p0_victim_tag_o (p0_victim_tag),
        .p1_resp_valid_o (p1_resp_valid),
        .p1_hit_o        (p1_hit),
        .p1_dirty_hit_o  (p1_dirty_hit)
    );

    always #4 clk_i = ~clk_i;

    // address layout is tag, index, byte offset
    assign wr_idx = wr_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign p0_idx = p0_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign p1_idx = p1_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign wr_tag = wr_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign p0_tag = p0_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign p1_tag = p1_addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    // lookups see the state before this edge's write
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                model_valid[i] <= 1'b0;
            end
            exp_p0_resp       <= 1'b0;
            exp_p0_hit        <= 1'b0;
            exp_p0_dirty      <= 1'b0;
            exp_p0_line_valid <= 1'b0;
            exp_p1_resp       <= 1'b0;
            exp_p1_hit        <= 1'b0;
            exp_p1_dirty_hit  <= 1'b0;
        end else begin
            exp_p0_resp       <= p0_lookup;
            exp_p0_hit        <= p0_lookup && model_valid[p0_idx] && model_tag[p0_idx] == p0_tag;
            exp_p0_dirty      <= p0_lookup && model_valid[p0_idx] && model_dirty[p0_idx];
            exp_p0_line_valid <= p0_lookup && model_valid[p0_idx];
            exp_p0_victim     <= model_tag[p0_idx];
            exp_p1_resp       <= p1_lookup;
            exp_p1_hit        <= p1_lookup && model_valid[p1_idx] && model_tag[p1_idx] == p1_tag;
            exp_p1_dirty_hit  <= p1_lookup && model_valid[p1_idx] && model_dirty[p1_idx]
                                 && model_tag[p1_idx] == p1_tag;
            if (wr_valid_we) begin
                model_valid[wr_idx] <= wr_valid;
                model_tag[wr_idx]   <= wr_tag;
            end
            if (wr_dirty_we) begin
                model_dirty[wr_idx] <= wr_dirty;
            end
        end
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
                                    name, expected, actual));
    endtask

    a_p0_resp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p0_resp_valid == exp_p0_resp)
        else report_mismatch("p0_resp_valid", 32'(exp_p0_resp), 32'(p0_resp_valid));
    a_p0_hit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p0_hit == exp_p0_hit)
        else report_mismatch("p0_hit", 32'(exp_p0_hit), 32'(p0_hit));
    a_p0_dirty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p0_dirty == exp_p0_dirty)
        else report_mismatch("p0_dirty", 32'(exp_p0_dirty), 32'(p0_dirty));
    // victim tag means something only for a valid line
    a_p0_victim : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exp_p0_line_valid |-> p0_victim_tag == exp_p0_victim)
        else report_mismatch("p0_victim_tag", 32'(exp_p0_victim), 32'(p0_victim_tag));
    a_p1_resp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p1_resp_valid == exp_p1_resp)
        else report_mismatch("p1_resp_valid", 32'(exp_p1_resp), 32'(p1_resp_valid));
    a_p1_hit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p1_hit == exp_p1_hit)
        else report_mismatch("p1_hit", 32'(exp_p1_hit), 32'(p1_hit));
    a_p1_dirty_hit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        p1_dirty_hit == exp_p1_dirty_hit)
        else report_mismatch("p1_dirty_hit", 32'(exp_p1_dirty_hit), 32'(p1_dirty_hit));

    function automatic logic [TAG_WIDTH-1:0] pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return TAG_WIDTH'(32'h0000_0001);
            2'd1:    return TAG_WIDTH'(32'h0002_aaaa);
            2'd2:    return TAG_WIDTH'(32'h003f_ffff);
            default: return TAG_WIDTH'(32'h0015_5555);
        endcase
    endfunction

    function automatic addr_t make_addr(input logic [INDEX_WIDTH-1:0] idx,
                                        input logic [TAG_WIDTH-1:0] tag,
                                        input logic [OFFSET_WIDTH-1:0] off);
        return {tag, idx, off};
    endfunction

    task automatic clear_strobes();
        p0_lookup   = 1'b0;
        p1_lookup   = 1'b0;
        wr_valid_we = 1'b0;
        wr_dirty_we = 1'b0;
    endtask

    // one cycle of stimulus, then wait for every response it asked for
    task automatic request(input logic l0, input addr_t a0, input logic l1, input addr_t a1,
                           input logic vwe, input logic dwe, input addr_t wa,
                           input logic v, input logic d);
        logic got0;
        logic got1;
        int   waited;
        @(negedge clk_i);
        p0_lookup   = l0;
        p0_addr     = a0;
        p1_lookup   = l1;
        p1_addr     = a1;
        wr_valid_we = vwe;
        wr_dirty_we = dwe;
        wr_addr     = wa;
        wr_valid    = v;
        wr_dirty    = d;
        got0        = !l0;
        got1        = !l1;
        waited      = 0;
        do begin
            @(negedge clk_i);
            clear_strobes();
            got0 = got0 || p0_resp_valid;
            got1 = got1 || p1_resp_valid;
            waited++;
            if (waited > RESP_TIMEOUT) begin
                stop_with_failure("no lookup response arrived within the timeout");
            end
        end while (!(got0 && got1));
    endtask

    initial begin
        rst_n_i  = 1'b0;
        wr_addr  = '0;
        wr_valid = 1'b0;
        wr_dirty = 1'b0;
        p0_addr  = '0;
        p1_addr  = '0;
        clear_strobes();
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;

        // every line misses right after reset
        for (int i = 0; i < DEPTH; i++) begin
            request(1'b1, make_addr(INDEX_WIDTH'(i), pick_tag(2'(i)), '0),
                    1'b1, make_addr(INDEX_WIDTH'(DEPTH - 1 - i), pick_tag(2'(i + 1)), '0),
                    1'b0, 1'b0, '0, 1'b0, 1'b0);
        end

        // give the lines used below a known dirty bit
        for (int i = 0; i < 4; i++) begin
            request(1'b0, '0, 1'b0, '0, 1'b0, 1'b1,
                    make_addr(INDEX_WIDTH'(i), '0, '0), 1'b0, 1'b0);
        end

        addr_a = make_addr(INDEX_WIDTH'(2), pick_tag(2'd1), 4'h8);
        addr_b = make_addr(INDEX_WIDTH'(2), pick_tag(2'd2), 4'h0);
        addr_c = make_addr(INDEX_WIDTH'(3), pick_tag(2'd0), 4'h4);

        request(1'b0, '0, 1'b0, '0, 1'b1, 1'b0, addr_a, 1'b1, 1'b0);
        request(1'b1, addr_a, 1'b1, addr_a, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        request(1'b1, addr_b, 1'b1, addr_b, 1'b0, 1'b0, '0, 1'b0, 1'b0);

        // dirty line, then the same line invalidated
        request(1'b0, '0, 1'b0, '0, 1'b0, 1'b1, addr_a, 1'b0, 1'b1);
        request(1'b1, addr_b, 1'b1, addr_a, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        request(1'b0, '0, 1'b0, '0, 1'b1, 1'b0, addr_a, 1'b0, 1'b0);
        request(1'b1, addr_b, 1'b1, addr_a, 1'b0, 1'b0, '0, 1'b0, 1'b0);

        // read before write at the same edge
        request(1'b1, addr_c, 1'b1, addr_c, 1'b1, 1'b0, addr_c, 1'b1, 1'b0);
        request(1'b1, addr_c, 1'b1, addr_c, 1'b0, 1'b0, '0, 1'b0, 1'b0);

        // back to back mixed traffic on four lines and four tags
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            @(negedge clk_i);
            r           = $random(seed);
            p0_lookup   = r[0];
            p1_lookup   = r[1];
            p0_addr     = make_addr(INDEX_WIDTH'(r[3:2]), pick_tag(r[5:4]), r[9:6]);
            p1_addr     = make_addr(INDEX_WIDTH'(r[11:10]), pick_tag(r[13:12]), r[17:14]);
            wr_valid_we = r[19:18] == 2'b00;
            wr_dirty_we = r[20] & r[21];
            wr_valid    = r[22] | r[23];
            wr_dirty    = r[24];
            wr_addr     = make_addr(INDEX_WIDTH'(r[26:25]), pick_tag(r[28:27]), r[31:28]);
        end
        @(negedge clk_i);
        clear_strobes();
        repeat (2) @(negedge clk_i);

        $display("Testbench passed");
        $finish;
    end

endmodule : tb_cache_lookup

// File: hdl/cache_lookup.sv
module cache_lookup #(
    parameter int  INDEX_WIDTH = cache_status_pkg::DEFAULT_INDEX_WIDTH,
    localparam int TAG_WIDTH   = cache_status_pkg::tag_width(INDEX_WIDTH)
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // line update
    input  cache_status_pkg::addr_t wr_addr_i,
    input  logic                    wr_valid_we_i,
    input  logic                    wr_dirty_we_i,
    input  logic                    wr_valid_i,
    input  logic                    wr_dirty_i,

    input  cache_status_pkg::addr_t p0_addr_i,
    input  cache_status_pkg::addr_t p1_addr_i,
    input  logic                    p0_lookup_i,
    input  logic                    p1_lookup_i,

    output logic                    p0_resp_valid_o,
    output logic                    p0_hit_o,
    output logic                    p0_dirty_o,
    output logic [TAG_WIDTH-1:0]    p0_victim_tag_o,

    // snoop port
    output logic                    p1_resp_valid_o,
    output logic                    p1_hit_o,
    output logic                    p1_dirty_hit_o
);

    import cache_status_pkg::*;

    localparam int TAG_LSB = OFFSET_WIDTH + INDEX_WIDTH;

    logic [INDEX_WIDTH-1:0] p0_index;
    logic [INDEX_WIDTH-1:0] p1_index;
    logic [TAG_WIDTH-1:0]   wr_tag;
    logic [TAG_WIDTH-1:0]   p0_req_tag;
    logic [TAG_WIDTH-1:0]   p1_req_tag;
    logic [TAG_WIDTH-1:0]   p0_mem_tag;
    logic [TAG_WIDTH-1:0]   p1_mem_tag;
    logic                   p0_mem_valid;
    logic                   p0_mem_dirty;
    logic                   p1_mem_valid;
    logic                   p1_mem_dirty;

    line_write_if #(.INDEX_WIDTH(INDEX_WIDTH), .TAG_WIDTH(TAG_WIDTH)) wr_if ();

    assign wr_if.valid_we  = wr_valid_we_i;
    assign wr_if.dirty_we  = wr_dirty_we_i;
    assign wr_if.index     = wr_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
    assign wr_if.valid_bit = wr_valid_i;
    assign wr_if.dirty_bit = wr_dirty_i;
    assign wr_tag          = wr_addr_i[TAG_LSB +: TAG_WIDTH];

    // byte offset plays no part in the lookup
    assign p0_index   = p0_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
    assign p1_index   = p1_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
    assign p0_req_tag = p0_addr_i[TAG_LSB +: TAG_WIDTH];
    assign p1_req_tag = p1_addr_i[TAG_LSB +: TAG_WIDTH];

    status_memory #(.INDEX_WIDTH(INDEX_WIDTH)) u_status_memory (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr         (wr_if.sink),
        .p0_index_i (p0_index),
        .p1_index_i (p1_index),
        .p0_read_i  (p0_lookup_i),
        .p1_read_i  (p1_lookup_i),
        .p0_valid_o (p0_mem_valid),
        .p0_dirty_o (p0_mem_dirty),
        .p1_valid_o (p1_mem_valid),
        .p1_dirty_o (p1_mem_dirty)
    );

    tag_memory #(.INDEX_WIDTH(INDEX_WIDTH), .TAG_WIDTH(TAG_WIDTH)) u_tag_memory (
        .clk_i      (clk_i),
        .wr         (wr_if.sink),
        .wr_tag_i   (wr_tag),
        .p0_index_i (p0_index),
        .p1_index_i (p1_index),
        .p0_read_i  (p0_lookup_i),
        .p1_read_i  (p1_lookup_i),
        .p0_tag_o   (p0_mem_tag),
        .p1_tag_o   (p1_mem_tag)
    );

    lookup_compare #(.TAG_WIDTH(TAG_WIDTH)) u_lookup_compare (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .p0_req_tag_i    (p0_req_tag),
        .p1_req_tag_i    (p1_req_tag),
        .p0_read_i       (p0_lookup_i),
        .p1_read_i       (p1_lookup_i),
        .p0_valid_i      (p0_mem_valid),
        .p0_dirty_i      (p0_mem_dirty),
        .p1_valid_i      (p1_mem_valid),
        .p1_dirty_i      (p1_mem_dirty),
        .p0_tag_i        (p0_mem_tag),
        .p1_tag_i        (p1_mem_tag),
        .p0_resp_valid_o (p0_resp_valid_o),
        .p0_hit_o        (p0_hit_o),
        .p0_dirty_o      (p0_dirty_o),
        .p0_victim_tag_o (p0_victim_tag_o),
        .p1_resp_valid_o (p1_resp_valid_o),
        .p1_hit_o        (p1_hit_o),
        .p1_dirty_hit_o  (p1_dirty_hit_o)
    );

endmodule : cache_lookup

// File: hdl/lookup_compare.sv
module lookup_compare #(
    parameter int TAG_WIDTH = cache_status_pkg::tag_width(cache_status_pkg::DEFAULT_INDEX_WIDTH)
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic [TAG_WIDTH-1:0] p0_req_tag_i,
    input  logic [TAG_WIDTH-1:0] p1_req_tag_i,
    input  logic                 p0_read_i,
    input  logic                 p1_read_i,

    input  logic                 p0_valid_i,
    input  logic                 p0_dirty_i,
    input  logic                 p1_valid_i,
    input  logic                 p1_dirty_i,
    input  logic [TAG_WIDTH-1:0] p0_tag_i,
    input  logic [TAG_WIDTH-1:0] p1_tag_i,

    output logic                 p0_resp_valid_o,
    output logic                 p0_hit_o,
    output logic                 p0_dirty_o,
    output logic [TAG_WIDTH-1:0] p0_victim_tag_o,

    output logic                 p1_resp_valid_o,
    output logic                 p1_hit_o,
    output logic                 p1_dirty_hit_o
);

    logic                 p0_read_q;
    logic                 p1_read_q;
    logic [TAG_WIDTH-1:0] p0_req_tag_q;
    logic [TAG_WIDTH-1:0] p1_req_tag_q;

    // line the request up with the memories' read data
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            p0_read_q <= 1'b0;
            p1_read_q <= 1'b0;
        end else begin
            p0_read_q <= p0_read_i;
            p1_read_q <= p1_read_i;
        end
    end

    always_ff @(posedge clk_i) begin
        p0_req_tag_q <= p0_req_tag_i;
        p1_req_tag_q <= p1_req_tag_i;
    end

    assign p0_resp_valid_o = p0_read_q;
    assign p0_hit_o        = p0_read_q && p0_valid_i && (p0_tag_i == p0_req_tag_q);
    // a dirty miss means the victim must be written back
    assign p0_dirty_o      = p0_read_q && p0_valid_i && p0_dirty_i;
    assign p0_victim_tag_o = p0_tag_i;

    assign p1_resp_valid_o = p1_read_q;
    assign p1_hit_o        = p1_read_q && p1_valid_i && (p1_tag_i == p1_req_tag_q);
    // snoop needs data only from a dirty hit
    assign p1_dirty_hit_o  = p1_hit_o && p1_dirty_i;

    // a valid line always carries the tag written with it
    a_p0_compare_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (p0_read_q && p0_valid_i) |-> !$isunknown({p0_tag_i, p0_req_tag_q})
    );

    a_p1_compare_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (p1_read_q && p1_valid_i) |-> !$isunknown({p1_tag_i, p1_req_tag_q})
    );

endmodule : lookup_compare

// File: hdl/tag_memory.sv
module tag_memory #(
    parameter int INDEX_WIDTH = cache_status_pkg::DEFAULT_INDEX_WIDTH,
    parameter int TAG_WIDTH   = cache_status_pkg::tag_width(INDEX_WIDTH)
) (
    input  logic                   clk_i,

    line_write_if.sink             wr,
    input  logic [TAG_WIDTH-1:0]   wr_tag_i,

    input  logic [INDEX_WIDTH-1:0] p0_index_i,
    input  logic [INDEX_WIDTH-1:0] p1_index_i,
    input  logic                   p0_read_i,
    input  logic                   p1_read_i,

    output logic [TAG_WIDTH-1:0]   p0_tag_o,
    output logic [TAG_WIDTH-1:0]   p1_tag_o
);

    localparam int DEPTH = 1 << INDEX_WIDTH;

    logic [TAG_WIDTH-1:0] tag_mem [DEPTH];

    // the tag is loaded together with the valid bit
    always_ff @(posedge clk_i) begin
        if (wr.valid_we) begin
            tag_mem[wr.index] <= wr_tag_i;
        end
    end

    // read registers hold their last value between strobes
    always_ff @(posedge clk_i) begin
        if (p0_read_i) begin
            p0_tag_o <= tag_mem[p0_index_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (p1_read_i) begin
            p1_tag_o <= tag_mem[p1_index_i];
        end
    end

endmodule : tag_memory

// File: hdl/status_memory.sv
module status_memory #(
    parameter int INDEX_WIDTH = cache_status_pkg::DEFAULT_INDEX_WIDTH
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    line_write_if.sink             wr,

    input  logic [INDEX_WIDTH-1:0] p0_index_i,
    input  logic [INDEX_WIDTH-1:0] p1_index_i,
    input  logic                   p0_read_i,
    input  logic                   p1_read_i,

    output logic                   p0_valid_o,
    output logic                   p0_dirty_o,
    output logic                   p1_valid_o,
    output logic                   p1_dirty_o
);

    localparam int DEPTH = 1 << INDEX_WIDTH;

    logic [DEPTH-1:0] valid_mem;
    logic             dirty_mem [DEPTH];

    // every line starts invalid
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_mem <= '0;
        end else if (wr.valid_we) begin
            valid_mem[wr.index] <= wr.valid_bit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr.dirty_we) begin
            dirty_mem[wr.index] <= wr.dirty_bit;
        end
    end

    // port 0 read sees the arrays as they were before this edge's write
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            p0_valid_o <= 1'b0;
            p0_dirty_o <= 1'b0;
        end else if (p0_read_i) begin
            p0_valid_o <= valid_mem[p0_index_i];
            p0_dirty_o <= dirty_mem[p0_index_i];
        end
    end

    // port 1 read for the snoop side
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            p1_valid_o <= 1'b0;
            p1_dirty_o <= 1'b0;
        end else if (p1_read_i) begin
            p1_valid_o <= valid_mem[p1_index_i];
            p1_dirty_o <= dirty_mem[p1_index_i];
        end
    end

    // an unknown write index would corrupt an arbitrary line
    a_wr_index_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (wr.valid_we || wr.dirty_we) |-> !$isunknown(wr.index)
    );

    a_p0_index_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        p0_read_i |-> !$isunknown(p0_index_i)
    );

    a_p1_index_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        p1_read_i |-> !$isunknown(p1_index_i)
    );

endmodule : status_memory

// File: hdl/line_write_if.sv
interface line_write_if #(
    parameter int INDEX_WIDTH = cache_status_pkg::DEFAULT_INDEX_WIDTH,
    parameter int TAG_WIDTH   = cache_status_pkg::tag_width(INDEX_WIDTH)
);

    // valid_we also loads the tag, which travels outside this bundle
    logic                   valid_we;
    logic                   dirty_we;
    logic [INDEX_WIDTH-1:0] index;
    logic                   valid_bit;
    logic                   dirty_bit;

    // the address split must leave room for both fields
    if (INDEX_WIDTH < 1 || TAG_WIDTH < 1) begin : g_bad_geometry
        $error("line_write_if: INDEX_WIDTH %0d and TAG_WIDTH %0d must be positive",
               INDEX_WIDTH, TAG_WIDTH);
    end

    modport source (
        output valid_we, dirty_we, index, valid_bit, dirty_bit
    );

    modport sink (
        input valid_we, dirty_we, index, valid_bit, dirty_bit
    );

endinterface : line_write_if

// File: hdl/cache_status_pkg.sv
package cache_status_pkg;

    // byte address and line geometry
    localparam int ADDR_WIDTH   = 32;
    localparam int OFFSET_WIDTH = 4;

    // 64 lines unless the top level is told otherwise
    localparam int DEFAULT_INDEX_WIDTH = 6;

    // whatever is left above index and offset is tag
    function automatic int tag_width(input int index_width);
        return ADDR_WIDTH - index_width - OFFSET_WIDTH;
    endfunction

    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage : cache_status_pkg
